// File: common/video_pkg.sv
// ===========================================================================
// Shared definitions for the video colour mixer
//   Pixel, palette index, bank and colour vector types
//   Control and palette write structs
//   APB address map and pixel pipeline depth
// ===========================================================================

package video_pkg;

    // APB address map, byte offsets
    localparam int ADDR_W = 12;                     // APB address width
    localparam logic [ADDR_W-1:0] PAL_BASE  = 12'h000; // Palette, one word per entry
    localparam logic [ADDR_W-1:0] CTRL_ADDR = 12'h400; // Bank and layer enables

    // Pixel enables from input sample to mixer output
    localparam int PIPE_DLY = 3;

    // Colour index of one layer inside its palette slice
    typedef logic [3:0] pxl_t;

    // Full palette address: bank, layer bit, pixel
    typedef logic [7:0] pal_idx_t;

    // Palette bank number
    typedef logic [2:0] pal_sel_t;

    // Packed colour, R in [11:8], G in [7:4], B in [3:0]
    typedef logic [11:0] rgb_t;

    // Control register as seen by the datapath
    typedef struct packed {
        pal_sel_t pal_sel;  // Bank
        logic     scr_en;   // Scroll layer on
        logic     obj_en;   // Object layer on
    } mix_ctrl_t;

    // Palette write request from the bus side
    typedef struct packed {
        logic     we;       // Write strobe, one clk wide
        pal_idx_t addr;     // Entry
        rgb_t     data;     // New colour
    } pal_wr_t;

endpackage

// File: src/pal_apb_regs.sv
// ===========================================================================
// APB slave of the colour mixer
//   Address decode for palette entries and the control register
//   Control register (bank, scroll enable, object enable)
//   Palette write request and read address to the palette RAM
//   Read data mux and error response for unmapped addresses
// ===========================================================================

`timescale 1ns/1ps

module pal_apb_regs (
    input  logic                          clk,
    input  logic                          rst_n,

    // APB slave
    input  logic [video_pkg::ADDR_W-1:0]  paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,

    // To the datapath
    output video_pkg::mix_ctrl_t          ctrl,
    output video_pkg::pal_wr_t            pal_wr,
    output video_pkg::pal_idx_t           rd_addr,
    input  video_pkg::rgb_t               rd_data
);

    logic access;       // Second APB phase
    logic pal_hit;      // Palette window 0x000..0x3FC
    logic ctrl_hit;     // Control register
    logic addr_err;     // Above the map

    assign access   = psel & penable;
    assign pal_hit  = paddr[video_pkg::ADDR_W-1:10] == video_pkg::PAL_BASE[video_pkg::ADDR_W-1:10];
    assign ctrl_hit = paddr == video_pkg::CTRL_ADDR;
    assign addr_err = paddr > video_pkg::CTRL_ADDR;

    // No wait states
    assign pready  = 1'b1;
    assign pslverr = access & addr_err;

    // Word address selects the entry
    assign rd_addr = paddr[9:2];

    // Palette write goes out on the access cycle, RAM takes it at that edge
    assign pal_wr.we   = access & pwrite & pal_hit;
    assign pal_wr.addr = paddr[9:2];
    assign pal_wr.data = pwdata[11:0];   // Upper bits ignored

    // Control register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0;                  // Both layers off, bank 0
        end else if (access && pwrite && ctrl_hit) begin
            ctrl.pal_sel <= pwdata[2:0];
            ctrl.scr_en  <= pwdata[4];
            ctrl.obj_en  <= pwdata[5];
        end
    end

    // Read data, combinational in the access cycle
    always_comb begin
        prdata = '0;
        if (pal_hit) begin
            prdata[11:0] = rd_data;      // Zero extended colour
        end else if (ctrl_hit) begin
            prdata[2:0] = ctrl.pal_sel;
            prdata[4]   = ctrl.scr_en;
            prdata[5]   = ctrl.obj_en;
        end
    end

endmodule

// File: colmix/pixel_priority.sv
// ===========================================================================
// Layer priority, first pixel stage
//   Object over scroll unless the object pixel is transparent or disabled
//   Scroll layer gating
//   Registered palette index built from bank, layer bit and pixel
// ===========================================================================

`timescale 1ns/1ps

module pixel_priority (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pxl_cen,
    input  video_pkg::pxl_t      obj_pxl,
    input  video_pkg::pxl_t      scr_pxl,
    input  video_pkg::mix_ctrl_t ctrl,
    output video_pkg::pal_idx_t  pal_idx
);

    logic            obj_blank;  // Object layer shows nothing here
    video_pkg::pxl_t scr_gated;  // Scroll pixel after its enable
    video_pkg::pxl_t pxl_sel;    // Winning pixel

    // Index zero is the transparent colour of the object layer
    assign obj_blank = (obj_pxl == '0) || !ctrl.obj_en;

    // Disabled scroll layer falls back to its colour 0
    assign scr_gated = ctrl.scr_en ? scr_pxl : '0;

    assign pxl_sel = obj_blank ? scr_gated : obj_pxl;

    // Index layout is {bank, layer, pixel}, layer 1 selects the scroll slice
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pal_idx <= '0;
        end else if (pxl_cen) begin
            pal_idx <= {ctrl.pal_sel, obj_blank, pxl_sel};
        end
    end

endmodule

// File: colmix/palette_lookup.sv
// ===========================================================================
// Palette lookup, second pixel stage
//   256 x 12 bit palette RAM
//   Pixel port with a registered read on each pixel enable
//   Processor port with a write on any clk edge and a combinational read
// ===========================================================================

`timescale 1ns/1ps

module palette_lookup (
    input  logic                clk,
    input  logic                pxl_cen,

    // Pixel side
    input  video_pkg::pal_idx_t pal_idx,
    output video_pkg::rgb_t     rgb,

    // Processor side
    input  video_pkg::pal_wr_t  pal_wr,
    input  video_pkg::pal_idx_t rd_addr,
    output video_pkg::rgb_t     rd_data
);

    // One entry per index value
    video_pkg::rgb_t pal_mem [2**$bits(video_pkg::pal_idx_t)];

    // Processor writes do not wait for a pixel enable
    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            pal_mem[pal_wr.addr] <= pal_wr.data;
        end
    end

    // Pixel read sees the old colour when a write hits the same entry
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            rgb <= pal_mem[pal_idx];
        end
    end

    // Bus read back
    assign rd_data = pal_mem[rd_addr];

endmodule

// File: colmix/blank_align.sv
// ===========================================================================
// Blank alignment, last pixel stage
//   Two stage delay of horizontal and vertical blanking
//   Output colour register, black while either blank is active
// ===========================================================================

`timescale 1ns/1ps

module blank_align (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pxl_cen,
    input  logic            lhbl,       // Active low
    input  logic            lvbl,       // Active low
    input  video_pkg::rgb_t rgb_in,     // From the palette, two enables behind
    output logic            lhbl_dly,
    output logic            lvbl_dly,
    output logic [3:0]      red,
    output logic [3:0]      green,
    output logic [3:0]      blue
);

    logic [1:0]      hbl_sr;    // Bit 1 lines up with rgb_in
    logic [1:0]      vbl_sr;
    logic            active;    // Visible area at the colour stage
    video_pkg::rgb_t rgb_q;

    assign active = hbl_sr[1] & vbl_sr[1];

    // Blanking follows the index and palette registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hbl_sr <= '0;          // Start blanked
            vbl_sr <= '0;
        end else if (pxl_cen) begin
            hbl_sr <= {hbl_sr[0], lhbl};
            vbl_sr <= {vbl_sr[0], lvbl};
        end
    end

    // Output stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            rgb_q    <= '0;
        end else if (pxl_cen) begin
            lhbl_dly <= hbl_sr[1];
            lvbl_dly <= vbl_sr[1];
            rgb_q    <= active ? rgb_in : '0;   // Black in the borders
        end
    end

    assign {red, green, blue} = rgb_q;

endmodule

// File: src/video_mixer_top.sv
// ===========================================================================
// Colour mixer top level
//   APB slave for palette and control
//   Pixel path of layer priority, palette lookup and blank alignment
// ===========================================================================

`timescale 1ns/1ps

module video_mixer_top (
    input  logic                         clk,
    input  logic                         rst_n,

    // APB slave
    input  logic [video_pkg::ADDR_W-1:0] paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,

    // Video in
    input  logic                         pxl_cen,
    input  video_pkg::pxl_t              obj_pxl,
    input  video_pkg::pxl_t              scr_pxl,
    input  logic                         lhbl,
    input  logic                         lvbl,

    // Video out
    output logic [3:0]                   red,
    output logic [3:0]                   green,
    output logic [3:0]                   blue,
    output logic                         lhbl_dly,
    output logic                         lvbl_dly
);

    video_pkg::mix_ctrl_t ctrl;      // Bank and layer enables
    video_pkg::pal_wr_t   pal_wr;    // Bus write to the palette
    video_pkg::pal_idx_t  rd_addr;   // Bus read entry
    video_pkg::rgb_t      rd_data;
    video_pkg::pal_idx_t  pal_idx;   // Stage 1 to stage 2
    video_pkg::rgb_t      rgb;       // Stage 2 to stage 3

    pal_apb_regs pal_apb_regs_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .ctrl     (ctrl),
        .pal_wr   (pal_wr),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    pixel_priority pixel_priority_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .obj_pxl  (obj_pxl),
        .scr_pxl  (scr_pxl),
        .ctrl     (ctrl),
        .pal_idx  (pal_idx)
    );

    palette_lookup palette_lookup_inst (
        .clk      (clk),
        .pxl_cen  (pxl_cen),
        .pal_idx  (pal_idx),
        .rgb      (rgb),
        .pal_wr   (pal_wr),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    // Blanks come straight from the ports, delay matched inside
    blank_align blank_align_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .rgb_in   (rgb),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

endmodule

// File: tb/tb_video_mixer.sv
// ===========================================================================
// Testbench for the colour mixer
//   Clock, reset and pixel enable on every second clock
//   APB write and read tasks, palette and control models
//   LFSR pixel and blanking stimulus over several bank and layer settings
//   Output stage assertions against a history of sampled inputs
//   Cycle limit watchdog
// ===========================================================================

`timescale 1ns/1ps

module tb_video_mixer;

    localparam int N_RUNS      = 6;                    // Pixel runs, one setting each
    localparam int RUN_LEN     = 200;                  // Clocks per run
    localparam int APB_CYC     = 3;                    // Clocks per APB transfer
    localparam int N_APB       = 256 + 64 + 10 + N_RUNS;
    localparam int CYCLE_LIMIT = N_APB * APB_CYC + N_RUNS * RUN_LEN + 200;
    localparam int LAST        = video_pkg::PIPE_DLY - 1;

    // Control word per run: bit 5 objects, bit 4 scroll, bits 2:0 bank
    localparam logic [31:0] RUN_CTRL [N_RUNS] = '{
        32'h0000_0030,  // Bank 0, both layers
        32'h0000_0013,  // Bank 3, scroll only
        32'h0000_0025,  // Bank 5, objects only
        32'h0000_0007,  // Bank 7, both off
        32'h0000_0032,  // Bank 2, both layers
        32'h0000_00F6   // Bank 6, both layers, stray upper bits
    };

    logic                         clk;
    logic                         rst_n;
    logic [video_pkg::ADDR_W-1:0] paddr;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [31:0]                  pwdata;
    logic [31:0]                  prdata;
    logic                         pready;
    logic                         pslverr;
    logic                         pxl_cen;
    video_pkg::pxl_t              obj_pxl;
    video_pkg::pxl_t              scr_pxl;
    logic                         lhbl;
    logic                         lvbl;
    logic [3:0]                   red;
    logic [3:0]                   green;
    logic [3:0]                   blue;
    logic                         lhbl_dly;
    logic                         lvbl_dly;

    logic [15:0]          lfsr = 16'd27046;           // Stimulus generator state
    video_pkg::rgb_t      pal_model [256];
    video_pkg::mix_ctrl_t ctrl_model = '0;            // Matches the reset value
    video_pkg::pal_idx_t  hist_idx [video_pkg::PIPE_DLY];
    logic                 hist_hbl [video_pkg::PIPE_DLY];
    logic                 hist_vbl [video_pkg::PIPE_DLY];
    int                   hist_cnt = 0;               // Enables seen, saturates
    logic                 chk_on = 1'b0;              // History full
    logic [11:0]          exp_rgb;
    int                   cycle_cnt = 0;

    int err_apb   = 0;
    int err_rst   = 0;
    int err_red   = 0;
    int err_green = 0;
    int err_blue  = 0;
    int err_hbl   = 0;
    int err_vbl   = 0;
    int err_black = 0;

    video_mixer_top video_mixer_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .pxl_cen  (pxl_cen),
        .obj_pxl  (obj_pxl),
        .scr_pxl  (scr_pxl),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #10 clk = ~clk;                       // 20 ns period
    end

    // Pixel enable on every second clock once out of reset
    initial begin : pixel_enable
        pxl_cen = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            pxl_cen = ~pxl_cen;
        end
    end

    // Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);                   // One step per bit
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Palette index from the layer rules
    function automatic video_pkg::pal_idx_t expected_index(
        input video_pkg::pxl_t      obj,
        input video_pkg::pxl_t      scr,
        input video_pkg::mix_ctrl_t c
    );
        logic            see_scroll;
        video_pkg::pxl_t scr_vis;
        see_scroll = (obj == 4'h0) || !c.obj_en;     // Transparent or objects off
        scr_vis    = c.scr_en ? scr : 4'h0;
        if (see_scroll) begin
            return {c.pal_sel, 1'b1, scr_vis};
        end
        return {c.pal_sel, 1'b0, obj};
    endfunction

    function automatic logic [31:0] ctrl_word(input video_pkg::mix_ctrl_t c);
        return {26'h0, c.obj_en, c.scr_en, 1'b0, c.pal_sel};
    endfunction

    function automatic int error_total();
        return err_apb + err_rst + err_red + err_green + err_blue
             + err_hbl + err_vbl + err_black;
    endfunction

    task automatic print_error_counts();
        $display("Errors: apb %0d, reset %0d, red %0d, green %0d, blue %0d, %s %0d, %s %0d, %s %0d",
                 err_apb, err_rst, err_red, err_green, err_blue,
                 "lhbl_dly", err_hbl, "lvbl_dly", err_vbl, "blanking", err_black);
    endtask

    // Sampled at the access cycle edge
    task automatic check_response(input logic [11:0] addr, input logic exp_err);
        assert (pready) else begin
            err_apb++;
            $display("APB access at %h did not complete, pready stayed low", addr);
        end
        assert (pslverr == exp_err) else begin
            err_apb++;
            $display("Fail pslverr at %h expected %h got %h", addr, exp_err, pslverr);
        end
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic exp_err);
        @(negedge clk);                               // Setup phase
        paddr   = addr;
        pwrite  = 1'b1;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;                               // Access phase
        @(posedge clk);
        check_response(addr, exp_err);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        // Models follow the address map
        if (addr < video_pkg::CTRL_ADDR) begin
            pal_model[addr[9:2]] = data[11:0];
        end else if (addr == video_pkg::CTRL_ADDR) begin
            ctrl_model.pal_sel = data[2:0];
            ctrl_model.scr_en  = data[4];
            ctrl_model.obj_en  = data[5];
        end
    endtask

    task automatic apb_read(input logic [11:0] addr, input logic exp_err,
                            input logic [31:0] exp_data);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        check_response(addr, exp_err);
        if (!exp_err) begin
            assert (prdata == exp_data) else begin
                err_apb++;
                $display("Fail prdata at %h expected %h got %h", addr, exp_data, prdata);
            end
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // New random pixel and blanks every clock, the DUT takes them on enables
    task automatic drive_pixels(input int n_clk);
        logic [31:0] r;
        repeat (n_clk) begin
            @(negedge clk);
            r = take_bits(1);
            if (r[0]) begin
                obj_pxl = 4'h0;                       // Extra transparent pixels
            end else begin
                r = take_bits(4);
                obj_pxl = r[3:0];
            end
            r = take_bits(4);
            scr_pxl = r[3:0];
            r = take_bits(2);
            lhbl = |r[1:0];                           // Blanked one time in four
            r = take_bits(2);
            lvbl = |r[1:0];
        end
    endtask

    // Input history, one entry per enable
    always @(posedge clk) begin
        if (rst_n && pxl_cen) begin
            for (int k = LAST; k > 0; k--) begin
                hist_idx[k] = hist_idx[k-1];
                hist_hbl[k] = hist_hbl[k-1];
                hist_vbl[k] = hist_vbl[k-1];
            end
            hist_idx[0] = expected_index(obj_pxl, scr_pxl, ctrl_model);
            hist_hbl[0] = lhbl;
            hist_vbl[0] = lvbl;
            if (hist_cnt < video_pkg::PIPE_DLY) begin
                hist_cnt++;
            end
            chk_on = hist_cnt >= video_pkg::PIPE_DLY;
        end
    end

    assign exp_rgb = (hist_hbl[LAST] && hist_vbl[LAST]) ? pal_model[hist_idx[LAST]] : 12'h000;

    // Output stage, checked mid cycle where the outputs are stable
    red_check: assert property (@(negedge clk) !chk_on || red == exp_rgb[11:8])
        else begin
            err_red++;
            $display("Fail red expected %h got %h at %0t", exp_rgb[11:8], red, $time);
        end

    green_check: assert property (@(negedge clk) !chk_on || green == exp_rgb[7:4])
        else begin
            err_green++;
            $display("Fail green expected %h got %h at %0t", exp_rgb[7:4], green, $time);
        end

    blue_check: assert property (@(negedge clk) !chk_on || blue == exp_rgb[3:0])
        else begin
            err_blue++;
            $display("Fail blue expected %h got %h at %0t", exp_rgb[3:0], blue, $time);
        end

    hbl_check: assert property (@(negedge clk) !chk_on || lhbl_dly == hist_hbl[LAST])
        else begin
            err_hbl++;
            $display("Fail lhbl_dly expected %h got %h at %0t", hist_hbl[LAST], lhbl_dly, $time);
        end

    vbl_check: assert property (@(negedge clk) !chk_on || lvbl_dly == hist_vbl[LAST])
        else begin
            err_vbl++;
            $display("Fail lvbl_dly expected %h got %h at %0t", hist_vbl[LAST], lvbl_dly, $time);
        end

    // Black whenever either delayed blank is active
    black_check: assert property (@(negedge clk)
        !rst_n || (lhbl_dly && lvbl_dly) || {red, green, blue} == 12'h000)
        else begin
            err_black++;
            $display("Fail rgb while blanked expected %h got %h at %0t",
                     12'h000, {red, green, blue}, $time);
        end

    initial begin : watchdog
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
        print_error_counts();
        $display("test failed");
        $finish;
    end

    initial begin : main
        logic [31:0] rnd;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        obj_pxl = 4'h0;
        scr_pxl = 4'h0;
        lhbl    = 1'b0;                               // Blanked until pixels run
        lvbl    = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // Reset values, no enable yet
        assert ({red, green, blue} == 12'h000) else begin
            err_rst++;
            $display("Fail rgb after reset expected %h got %h", 12'h000, {red, green, blue});
        end
        assert (!lhbl_dly && !lvbl_dly) else begin
            err_rst++;
            $display("Fail lhbl_dly/lvbl_dly after reset expected 0 0 got %h %h",
                     lhbl_dly, lvbl_dly);
        end
        assert (!pslverr) else begin
            err_rst++;
            $display("Fail pslverr after reset expected 0 got %h", pslverr);
        end

        // Full palette load, bits 15:12 are junk the RAM drops
        for (int i = 0; i < 256; i++) begin
            rnd = take_bits(16);
            apb_write({2'b00, i[7:0], 2'b00}, {16'h0, rnd[15:0]}, 1'b0);
        end
        repeat (64) begin
            rnd = take_bits(8);
            apb_read({2'b00, rnd[7:0], 2'b00}, 1'b0, {20'h0, pal_model[rnd[7:0]]});
        end

        // Unmapped addresses, entries 1 and 255 alias their low bits
        apb_write(12'h404, 32'h0000_0FFF, 1'b1);
        apb_write(12'hBFC, 32'h0000_0ABC, 1'b1);
        apb_read(12'hFFC, 1'b1, 32'h0);
        apb_read(12'h004, 1'b0, {20'h0, pal_model[1]});
        apb_read(12'h3FC, 1'b0, {20'h0, pal_model[255]});
        apb_read(video_pkg::CTRL_ADDR, 1'b0, ctrl_word(ctrl_model));

        // Control register read back, undefined bits read as zero
        apb_write(video_pkg::CTRL_ADDR, 32'hFFFF_FFED, 1'b0);    // Objects on, scroll off
        apb_read(video_pkg::CTRL_ADDR, 1'b0, ctrl_word(ctrl_model));
        apb_write(video_pkg::CTRL_ADDR, 32'hFFFF_FFDA, 1'b0);    // Scroll on, objects off
        apb_read(video_pkg::CTRL_ADDR, 1'b0, ctrl_word(ctrl_model));

        // Pixel runs, bank and enables change between them
        for (int r = 0; r < N_RUNS; r++) begin
            apb_write(video_pkg::CTRL_ADDR, RUN_CTRL[r], 1'b0);
            drive_pixels(RUN_LEN);
        end
        repeat (4 * video_pkg::PIPE_DLY) @(negedge clk);   // Drain the pipeline

        print_error_counts();
        if (error_total() == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: list.f
common/video_pkg.sv
src/pal_apb_regs.sv
colmix/pixel_priority.sv
colmix/palette_lookup.sv
colmix/blank_align.sv
src/video_mixer_top.sv
tb/tb_video_mixer.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the colour mixer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f list.f \
    --top-module tb_video_mixer \
    -Mdir obj_dir -o tb_sim

./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -q "test failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished without failure"
